// ==== Makefile ====
# Verilator build and run for the data memory subsystem

VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= All tests passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/mem_subsys_tb.sv ====
// memory subsystem testbench

`timescale 1ns/1ps

module mem_subsys_tb;

	localparam int SRAM_AW    = 4;
	localparam int SRAM_BYTES = 1 << (SRAM_AW + 4);
	localparam int CLK_PERIOD = 10;

	// request slots per phase with the idle slots of the mix.
	localparam int IO_INIT_REQS  = 4;
	localparam int ALIGNED_REQS  = 2 * (SRAM_BYTES / 8);
	localparam int MISALIGN_REQS = 300;
	localparam int IO_REQS       = 100;
	localparam int UNMAPPED_REQS = 50;
	localparam int READBACK_REQS = SRAM_BYTES / 8 + 4;
	localparam int MIX_SLOTS     = 2000;
	localparam int TOTAL_REQS    = IO_INIT_REQS + ALIGNED_REQS + MISALIGN_REQS + IO_REQS
		+ UNMAPPED_REQS + READBACK_REQS + MIX_SLOTS;

	localparam int REG_SRAM = 0;
	localparam int REG_IO   = 1;
	localparam int REG_NONE = 2;

	typedef struct packed {
		mem_bus_pkg::data_t data;
		mem_bus_pkg::data_t mask;  // bytes with a known value.
	} expect_t;

	logic                  CLK;
	logic                  reset;
	mem_bus_pkg::mem_req_t req;
	mem_bus_pkg::mem_rsp_t rsp;

	integer seed   = 76;
	int     errors = 0;
	int     checks = 0;

	logic [7:0]         sram_model [SRAM_BYTES];
	bit                 known [SRAM_BYTES];  // sram holds garbage until written.
	mem_bus_pkg::data_t io_model [mem_bus_pkg::IO_REGS];
	expect_t            exp_q [$];

	mem_subsys #(
		.SRAM_AW(SRAM_AW)
	) mem_subsys_inst (
		.CLK(CLK),
		.reset(reset),
		.req(req),
		.rsp(rsp)
	);

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic mem_bus_pkg::data_t rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = rand32();
		lo = rand32();
		return {hi, lo};
	endfunction

	// window is decided by all bits above bit 27.
	function automatic int region_of(input mem_bus_pkg::addr_t a);
		if (a[63:28] == mem_bus_pkg::SRAM_BASE[63:28]) begin
			return REG_SRAM;
		end else if (a[63:28] == mem_bus_pkg::IO_BASE[63:28]) begin
			return REG_IO;
		end
		return REG_NONE;
	endfunction

	// random mirror bits above the sram size.
	function automatic mem_bus_pkg::addr_t sram_addr(input int off);
		mem_bus_pkg::addr_t mirror;
		mirror = rand64() & mem_bus_pkg::REGION_MASK & ~mem_bus_pkg::addr_t'(SRAM_BYTES - 1);
		return mem_bus_pkg::SRAM_BASE | mirror | mem_bus_pkg::addr_t'(off);
	endfunction

	function automatic mem_bus_pkg::addr_t io_addr(input int idx);
		mem_bus_pkg::addr_t a;
		int low;
		low = 1 + int'(rand32() % 7);  // never zero.
		a = mem_bus_pkg::IO_BASE | (rand64() & mem_bus_pkg::REGION_MASK);
		a[4:3] = idx[1:0];
		a[2:0] = low[2:0];
		return a;
	endfunction

	function automatic mem_bus_pkg::addr_t unmapped_addr();
		mem_bus_pkg::addr_t a;
		int kind;
		kind = int'(rand32() % 3);
		if (kind == 0) begin
			a = rand64();
		end else if (kind == 1) begin
			a = 64'hA000_0000 | (rand64() & mem_bus_pkg::REGION_MASK);
		end else begin
			a = mem_bus_pkg::SRAM_BASE | (64'h1 << (32 + rand32() % 32));  // high bits only.
		end
		while (region_of(a) != REG_NONE) begin
			a = rand64();
		end
		return a;
	endfunction

	// old data first and the strobed write after it.
	function automatic expect_t model_access(input mem_bus_pkg::addr_t a,
			input mem_bus_pkg::data_t d, input mem_bus_pkg::strb_t s);
		expect_t e;
		int off;
		int b;
		logic [1:0] idx;
		e.data = '0;
		e.mask = '1;
		case (region_of(a))
			REG_SRAM: begin
				off = int'(a[SRAM_AW+3:0]);
				for (int i = 0; i < 8; i++) begin
					b = (off + i) % SRAM_BYTES;  // wraps at the top.
					e.data[i*8 +: 8] = sram_model[b];
					e.mask[i*8 +: 8] = known[b] ? 8'hFF : 8'h00;
				end
				for (int i = 0; i < 8; i++) begin
					b = (off + i) % SRAM_BYTES;
					if (s[i]) begin
						sram_model[b] = d[i*8 +: 8];
						known[b] = 1'b1;
					end
				end
			end
			REG_IO: begin
				idx = a[4:3];
				e.data = io_model[idx];
				for (int i = 0; i < 8; i++) begin
					if (s[i]) begin
						io_model[idx][i*8 +: 8] = d[i*8 +: 8];
					end
				end
			end
			default: e.data = '0;
		endcase
		return e;
	endfunction

	task automatic issue(input mem_bus_pkg::addr_t a, input mem_bus_pkg::data_t d,
			input mem_bus_pkg::strb_t s);
		@(posedge CLK);
		req.valid <= 1'b1;
		req.addr  <= a;
		req.wdata <= d;
		req.wstrb <= s;
	endtask

	task automatic idle();
		@(posedge CLK);
		req.valid <= 1'b0;
	endtask

	// response of the request accepted at the last edge.
	always @(negedge CLK) begin : check_rsp
		expect_t e;
		if (reset) begin
			for (int r = 0; r < mem_bus_pkg::IO_REGS; r++) begin
				io_model[r] = '0;
			end
		end
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			checks++;
			assert (rsp.valid === 1'b1) else begin
				errors++;
				$display("FAILED %0t ns rsp.valid expected 1 actual %b", $time, rsp.valid);
			end
			assert ((rsp.rdata & e.mask) === (e.data & e.mask)) else begin
				errors++;
				$display("FAILED %0t ns rsp.rdata expected %h actual %h", $time,
					e.data & e.mask, rsp.rdata & e.mask);
			end
		end else begin
			assert (rsp.valid === 1'b0) else begin
				errors++;
				$display("response valid at %0t ns without any request", $time);
			end
		end
		if (req.valid === 1'b1) begin
			exp_q.push_back(model_access(req.addr, req.wdata, req.wstrb));
		end
	end

	initial begin : stimulus
		mem_bus_pkg::addr_t a;
		mem_bus_pkg::addr_t last_addr;
		mem_bus_pkg::strb_t s;
		logic [31:0] r;
		logic follow;
		int off;
		int pick;
		req <= '0;
		reset <= 1'b1;
		last_addr = '0;
		follow = 1'b0;
		repeat (3) @(posedge CLK);
		reset <= 1'b0;

		for (int i = 0; i < IO_INIT_REQS; i++) begin
			issue(io_addr(i), rand64(), 8'h00);  // zero out of reset.
		end
		for (int w = 0; w < ALIGNED_REQS / 2; w++) begin
			issue(sram_addr(w * 8), rand64(), 8'hFF);
		end
		for (int w = 0; w < ALIGNED_REQS / 2; w++) begin
			issue(sram_addr(w * 8), rand64(), 8'h00);
		end
		// every fourth access straddles the top of the sram.
		for (int n = 0; n < MISALIGN_REQS; n++) begin
			r = rand32();
			off = (n % 4 == 0) ? SRAM_BYTES - 1 - int'(r[2:0]) : int'(rand32() % SRAM_BYTES);
			s = r[15:8];
			issue(sram_addr(off), rand64(), s);
		end
		for (int n = 0; n < IO_REQS; n++) begin
			r = rand32();
			s = (r[9:8] == 2'd0) ? 8'h00 : r[7:0];
			issue(io_addr(int'(r[11:10])), rand64(), s);
		end
		for (int n = 0; n < UNMAPPED_REQS; n++) begin
			r = rand32();
			issue(unmapped_addr(), rand64(), r[7:0] | 8'h01);
		end
		// nothing may have changed behind the unmapped writes.
		for (int w = 0; w < SRAM_BYTES / 8; w++) begin
			issue(sram_addr(w * 8), rand64(), 8'h00);
		end
		for (int i = 0; i < 4; i++) begin
			issue(io_addr(i), rand64(), 8'h00);
		end

		for (int n = 0; n < MIX_SLOTS; n++) begin
			r = rand32();
			if (follow && r[0]) begin
				issue(last_addr, rand64(), 8'h00);  // same bytes on the very next cycle.
				follow = 1'b0;
			end else if (r[3:1] == 3'd0) begin
				idle();
				follow = 1'b0;
			end else begin
				pick = int'(r[7:4]);
				if (pick < 10) begin
					a = sram_addr(int'(rand32() % SRAM_BYTES));
				end else if (pick < 14) begin
					a = io_addr(int'(rand32() % 4));
				end else begin
					a = unmapped_addr();
				end
				s = r[16] ? 8'h00 : r[15:8];
				issue(a, rand64(), s);
				last_addr = a;
				follow = (s != 8'h00);
			end
		end
		idle();
		repeat (2) @(negedge CLK);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		#((TOTAL_REQS + 200) * CLK_PERIOD);
		$display("timeout, run still busy after %0d ns", (TOTAL_REQS + 200) * CLK_PERIOD);
		$display("checks %0d, errors %0d", checks, errors + 1);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== src/io_regs.sv ====
// peripheral scratch registers

`timescale 1ns/1ps

module io_regs (
	input  logic                  CLK,
	input  logic                  reset,
	input  mem_bus_pkg::io_req_t  io_req,
	output mem_bus_pkg::data_t    io_rdata
);

	mem_bus_pkg::data_t regs [mem_bus_pkg::IO_REGS];

	// strobed byte writes, registers clear on reset.
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int r = 0; r < mem_bus_pkg::IO_REGS; r++) begin
				regs[r] <= '0;
			end
		end else if (io_req.sel) begin
			for (int i = 0; i < 8; i++) begin
				if (io_req.wstrb[i]) begin
					regs[io_req.idx][i*8 +: 8] <= io_req.wdata[i*8 +: 8];
				end
			end
		end
	end

	// read data is the value before this write.
	always_ff @(posedge CLK) begin
		if (io_req.sel) begin
			io_rdata <= regs[io_req.idx];
		end
	end

endmodule

// ==== src/mem_bus.sv ====
// load/store bus with split sram banks

`timescale 1ns/1ps

module mem_bus #(
	parameter int SRAM_AW = 11
) (
	input  logic                   CLK,
	input  logic                   reset,
	input  mem_bus_pkg::mem_req_t  req,
	output mem_bus_pkg::mem_rsp_t  rsp,
	output mem_bus_pkg::io_req_t   io_req,
	input  mem_bus_pkg::data_t     io_rdata
);

	// one 16-byte line, even half low and odd half high.
	typedef logic [127:0] line_t;
	typedef logic [15:0]  line_strb_t;

	// state carried from the request edge to the response cycle.
	typedef struct packed {
		logic       valid;
		logic       is_sram;
		logic       is_io;
		logic       swap;   // access started in the odd half.
		logic [2:0] shift;  // byte offset inside the half.
	} rsp_ctl_t;

	logic is_sram;
	logic is_io;
	logic swap;
	logic [2:0] shift;

	line_t      wline;
	line_strb_t wline_strb;

	logic [SRAM_AW-1:0] row;
	logic [SRAM_AW-1:0] row_next;
	logic               bank_en;

	logic [SRAM_AW-1:0] eve_addr;
	logic [SRAM_AW-1:0] odd_addr;
	mem_bus_pkg::data_t eve_wdata;
	mem_bus_pkg::data_t odd_wdata;
	mem_bus_pkg::strb_t eve_wstrb;
	mem_bus_pkg::strb_t odd_wstrb;
	mem_bus_pkg::data_t eve_rdata;
	mem_bus_pkg::data_t odd_rdata;

	rsp_ctl_t ctl_d;
	rsp_ctl_t ctl_q;

	line_t              rline;
	mem_bus_pkg::data_t sram_rdata;

	// region decode on the upper 36 bits.
	assign is_sram = (req.addr & ~mem_bus_pkg::REGION_MASK) == mem_bus_pkg::SRAM_BASE;
	assign is_io   = (req.addr & ~mem_bus_pkg::REGION_MASK) == mem_bus_pkg::IO_BASE;

	assign swap  = req.addr[3];
	assign shift = req.addr[2:0];

	// move data and strobes to their byte lanes across the line.
	assign wline      = line_t'(req.wdata) << {shift, 3'b000};
	assign wline_strb = line_strb_t'(req.wstrb) << shift;

	// row wraps at the top of the sram.
	assign row      = req.addr[4 +: SRAM_AW];
	assign row_next = row + 1'b1;
	assign bank_en  = req.valid & is_sram;

	// odd half always sits in the start row.
	assign odd_addr  = row;
	assign odd_wdata = swap ? wline[63:0] : wline[127:64];
	assign odd_wstrb = swap ? wline_strb[7:0] : wline_strb[15:8];

	// even half spills into the next row when the access starts odd.
	assign eve_addr  = swap ? row_next : row;
	assign eve_wdata = swap ? wline[127:64] : wline[63:0];
	assign eve_wstrb = swap ? wline_strb[15:8] : wline_strb[7:0];

	sram_bank #(
		.SRAM_AW(SRAM_AW)
	) sram_eve_inst (
		.CLK(CLK),
		.en(bank_en),
		.addr(eve_addr),
		.wdata(eve_wdata),
		.wstrb(eve_wstrb),
		.rdata(eve_rdata)
	);

	sram_bank #(
		.SRAM_AW(SRAM_AW)
	) sram_odd_inst (
		.CLK(CLK),
		.en(bank_en),
		.addr(odd_addr),
		.wdata(odd_wdata),
		.wstrb(odd_wstrb),
		.rdata(odd_rdata)
	);

	// peripheral side, index from bits 4:3.
	always_comb begin
		io_req.sel   = req.valid & is_io;
		io_req.idx   = req.addr[4:3];
		io_req.wdata = req.wdata;
		io_req.wstrb = req.wstrb;
	end

	always_comb begin
		ctl_d.valid   = req.valid;
		ctl_d.is_sram = is_sram;
		ctl_d.is_io   = is_io;
		ctl_d.swap    = swap;
		ctl_d.shift   = shift;
	end

	// decode held only while a request is pending.
	always_ff @(posedge CLK) begin
		if (reset) begin
			ctl_q <= '0;
		end else if (req.valid) begin
			ctl_q <= ctl_d;
		end else begin
			ctl_q.valid <= 1'b0;
		end
	end

	// put the two halves back in address order.
	assign rline      = ctl_q.swap ? {eve_rdata, odd_rdata} : {odd_rdata, eve_rdata};
	assign sram_rdata = mem_bus_pkg::data_t'(rline >> {ctl_q.shift, 3'b000});

	always_comb begin
		rsp.valid = ctl_q.valid;
		if (ctl_q.is_sram) begin
			rsp.rdata = sram_rdata;
		end else if (ctl_q.is_io) begin
			rsp.rdata = io_rdata;
		end else begin
			rsp.rdata = '0;  // unmapped.
		end
	end

endmodule

// ==== src/mem_bus_pkg.sv ====
// data memory bus definitions

package mem_bus_pkg;

	// widths with a meaning of their own.
	typedef logic [63:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0]  strb_t;

	// region decode ignores the low 28 address bits.
	localparam addr_t REGION_MASK = 64'h0000_0000_0FFF_FFFF;

	// 256 MB windows, the sram mirrors inside its own.
	localparam addr_t SRAM_BASE = 64'h0000_0000_8000_0000;
	localparam addr_t IO_BASE   = 64'h0000_0000_9000_0000;

	// scratch registers in the peripheral window.
	localparam int IO_REGS = 4;

	// load/store port request, any strobe bit makes it a write.
	typedef struct packed {
		logic  valid;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
	} mem_req_t;

	// response, one cycle after the request.
	typedef struct packed {
		logic  valid;
		data_t rdata;
	} mem_rsp_t;

	// request as seen by the peripheral block.
	typedef struct packed {
		logic       sel;
		logic [1:0] idx;  // address bits 4:3.
		data_t      wdata;
		strb_t      wstrb;
	} io_req_t;

endpackage

// ==== src/mem_subsys.sv ====
// data memory subsystem top

`timescale 1ns/1ps

module mem_subsys #(
	parameter int SRAM_AW = 11  // bank row address width.
) (
	input  logic                   CLK,
	input  logic                   reset,
	input  mem_bus_pkg::mem_req_t  req,
	output mem_bus_pkg::mem_rsp_t  rsp
);

	mem_bus_pkg::io_req_t io_req;
	mem_bus_pkg::data_t   io_rdata;

	// decode, sram banks and response mux.
	mem_bus #(
		.SRAM_AW(SRAM_AW)
	) mem_bus_inst (
		.CLK(CLK),
		.reset(reset),
		.req(req),
		.rsp(rsp),
		.io_req(io_req),
		.io_rdata(io_rdata)
	);

	// peripheral window.
	io_regs io_regs_inst (
		.CLK(CLK),
		.reset(reset),
		.io_req(io_req),
		.io_rdata(io_rdata)
	);

endmodule

// ==== src/sram_bank.sv ====
// synchronous sram bank

`timescale 1ns/1ps

module sram_bank #(
	parameter int SRAM_AW = 11
) (
	input  logic                  CLK,
	input  logic                  en,
	input  logic [SRAM_AW-1:0]    addr,
	input  mem_bus_pkg::data_t    wdata,
	input  mem_bus_pkg::strb_t    wstrb,
	output mem_bus_pkg::data_t    rdata
);

	// one 64-bit word per row.
	mem_bus_pkg::data_t mem [2**SRAM_AW];

	// read port, old row is captured before the write lands.
	always_ff @(posedge CLK) begin
		if (en) begin
			rdata <= mem[addr];
		end
	end

	// byte lane writes.
	always_ff @(posedge CLK) begin
		if (en) begin
			for (int i = 0; i < 8; i++) begin
				if (wstrb[i]) begin
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== vlog.f ====
src/mem_bus_pkg.sv
src/sram_bank.sv
src/io_regs.sv
src/mem_bus.sv
src/mem_subsys.sv
dv/mem_subsys_tb.sv
